/* Bender.yml */
package:
  name: motor_dac_ctrl

sources:
  - files:
      - verilog/motor_dac_pkg.sv
      - verilog/axi_cmd_slave.sv
      - verilog/motor_cmd_regs.sv
      - verilog/dac_frame_shifter.sv
      - verilog/dac_sequencer.sv
      - verilog/convst_timer.sv
      - verilog/status_writer.sv
      - verilog/motor_dac_ctrl.sv
  - target: test
    files:
      - bench/tb_dac_model.sv
      - bench/tb_motor_dac_ctrl.sv

/* bench/motor_dac_vectors.txt */
# motor_key dir_key voltage alarm_key period corrupt, all hex
# corrupt 1 makes the DAC model return a wrong readback
EAEA 1EAF 155 AAED 00000014 0
EAEA 0000 2AA 0000 00000020 0
0000 1EAF 3FF AAED 00000010 1
EAEA 1EAF 000 1234 0000001F 0
EAEA FFFF 001 AAED 00000030 1
1234 1EAF 200 AAED 00000008 0
EAEA 1EAF 3FE 0000 0000000C 0
EAEA 1EAF 123 AAEE 00000040 0
EAEB 1EAE 0F0 AAED 00000005 1
EAEA 0000 37C 0000 00000050 0

/* bench/tb_dac_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dac_model (
	input  wire       i_sclk,
	input  wire       i_sync_n,
	input  wire       i_sdin,
	input  wire [9:0] i_voltage,
	input  wire       i_corrupt,	// Flip lowest readback bit
	output logic      o_sdo
);

	logic [23:0] frame_log [0:63];
	int          frame_count = 0;
	logic [23:0] rx_sr = '0;
	logic [23:0] tx_sr = '0;
	logic        frame_open = 1'b0;
	logic        read_pending = 1'b0;	// Last frame was a read request

	initial o_sdo = 1'b0;

	// ****************************************
	// Frame opens, readback only after a read
	// ****************************************
	always @(negedge i_sync_n) begin
		frame_open = 1'b1;
		rx_sr      = '0;
		tx_sr      = read_pending ? {12'd0, i_voltage ^ {9'd0, i_corrupt}, 2'b00} : '0;
		o_sdo      = tx_sr[23];	// First bit ready before first rising edge
	end

	always @(posedge i_sclk) begin
		if (!i_sync_n && frame_open) begin
			rx_sr = {rx_sr[22:0], i_sdin};
			tx_sr = {tx_sr[22:0], 1'b0};
			o_sdo = tx_sr[23];
		end
	end

	// Frame closes
	always @(posedge i_sync_n) begin
		if (frame_open) begin
			if (frame_count < 64)
				frame_log[frame_count] = rx_sr;
			frame_count  = frame_count + 1;
			read_pending = (rx_sr[23:20] == 4'h9);
			frame_open   = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* bench/tb_motor_dac_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_motor_dac_ctrl;

	localparam int TIMEOUT_SHORT = 100;
	localparam int TIMEOUT_SEQ   = 3000;	// Three frames plus status burst
	localparam int IDLE_WINDOW   = 200;

	// Selectors for wait_until
	localparam int SIG_AWREADY = 0;
	localparam int SIG_WREADY  = 1;
	localparam int SIG_BVALID  = 2;
	localparam int SIG_BCLEAR  = 3;
	localparam int SIG_RESET_N = 4;
	localparam int SIG_BURST   = 5;
	localparam int SIG_TRIG    = 6;

	logic        sys_clk = 1'b0;
	logic        sys_rst;
	logic        i_s_awvalid, i_s_wvalid, i_s_wlast, i_s_bready;
	logic [63:0] i_s_wdata;
	logic        o_s_awready, o_s_wready, o_s_bvalid;
	logic [1:0]  o_s_bresp;
	logic        i_m_awready, i_m_wready, i_m_bvalid;
	logic        o_m_awvalid, o_m_wvalid, o_m_wlast, o_m_bready;
	logic [31:0] o_m_awaddr;
	logic [3:0]  o_m_awid;
	logic [7:0]  o_m_awlen;
	logic [1:0]  o_m_awburst;
	logic [63:0] o_m_wdata;
	logic [7:0]  o_m_wstrb;
	logic        o_dac_sclk, o_dac_sync_n, o_dac_sdin, o_dac_reset_n, i_dac_sdo;
	logic        o_motor_state, o_motor_direction, o_motor_alarm_reset, o_trig_ad_convst;

	logic [9:0]  cur_volt;	// Readback source for the DAC model
	logic        cur_corrupt;
	logic [31:0] lcg_state = 32'd53;
	logic [31:0] rnd;

	// Status burst capture
	logic [31:0] aw_addr;
	logic [3:0]  aw_id;
	logic [7:0]  aw_len;
	logic [1:0]  aw_burst;
	logic [63:0] beat_data [0:1];
	logic        beat_last [0:1];
	logic [7:0]  beat_strb [0:1];
	int          beat_idx = 0;
	logic        resp_due = 1'b0;
	int          bursts_done = 0;
	int          bursts_target = 0;

	motor_dac_ctrl #(.SCLK_DIV(6), .STATUS_ADDR(32'h1000)) u_motor_dac_ctrl (.*);

	tb_dac_model u_dac_model (
		.i_sclk    (o_dac_sclk),
		.i_sync_n  (o_dac_sync_n),
		.i_sdin    (o_dac_sdin),
		.i_voltage (cur_volt),
		.i_corrupt (cur_corrupt),
		.o_sdo     (i_dac_sdo)
	);

	initial begin
		forever #4 sys_clk = ~sys_clk;	// 8 ns period
	end

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ****************************************
	// Back-pressure and status slave
	// ****************************************
	always @(negedge sys_clk) begin
		rnd         = lcg_next();
		i_m_awready = rnd[16];
		i_m_wready  = rnd[20] | rnd[21];	// Mostly ready
		i_s_bready  = rnd[24];
		i_m_bvalid  = resp_due;
	end

	always @(posedge sys_clk) begin
		if (o_m_awvalid && i_m_awready) begin
			aw_addr  = o_m_awaddr;
			aw_id    = o_m_awid;
			aw_len   = o_m_awlen;
			aw_burst = o_m_awburst;
		end
		if (o_m_wvalid && i_m_wready) begin
			beat_data[beat_idx] = o_m_wdata;
			beat_last[beat_idx] = o_m_wlast;
			beat_strb[beat_idx] = o_m_wstrb;
			resp_due = o_m_wlast;	// Answer after the last beat
			beat_idx = o_m_wlast ? 0 : 1;
		end
		if (i_m_bvalid && o_m_bready) begin
			resp_due    = 1'b0;
			bursts_done = bursts_done + 1;
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "stopping the run");
	endtask

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("Done: errors found");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	function logic sample_signal(input int sel);
		case (sel)
			SIG_AWREADY: return o_s_awready;
			SIG_WREADY:  return o_s_wready;
			SIG_BVALID:  return o_s_bvalid;
			SIG_BCLEAR:  return !o_s_bvalid;
			SIG_RESET_N: return o_dac_reset_n;
			SIG_BURST:   return bursts_done == bursts_target;
			default:     return o_trig_ad_convst;
		endcase
	endfunction

	// Checks at the current falling edge first, then one edge at a time
	task automatic wait_until(input int sel, input string what, input int limit);
		int count = 0;
		while (!sample_signal(sel)) begin
			@(negedge sys_clk);
			count++;
			if (count > limit)
				fail_run({"timeout while waiting for ", what});
		end
	endtask

	task automatic run_vector(input logic [15:0] mk, input logic [15:0] dk,
		input logic [9:0] volt, input logic [15:0] ak, input logic [31:0] period,
		input logic corrupt);
		int frames_before;
		int gap;
		int n;
		cur_volt      = volt;
		cur_corrupt   = corrupt;
		bursts_target = bursts_done + 1;
		frames_before = u_dac_model.frame_count;

		// ****************************************
		// Command burst, two beats
		// ****************************************
		i_s_awvalid = 1'b1;
		wait_until(SIG_AWREADY, "command address ready", TIMEOUT_SHORT);
		@(negedge sys_clk);
		i_s_awvalid = 1'b0;
		i_s_wvalid  = 1'b1;
		i_s_wdata   = {mk, dk, 6'd0, volt, ak};	// Field view
		wait_until(SIG_WREADY, "command beat one", TIMEOUT_SHORT);
		@(negedge sys_clk);
		i_s_wdata = {period, 32'd0};	// Period view
		i_s_wlast = 1'b1;
		wait_until(SIG_WREADY, "command beat two", TIMEOUT_SHORT);
		@(negedge sys_clk);
		i_s_wvalid = 1'b0;
		i_s_wlast  = 1'b0;
		wait_until(SIG_BVALID, "command response", TIMEOUT_SHORT);
		compare_value("command bresp", 2'b00, o_s_bresp);
		wait_until(SIG_BCLEAR, "command response to be taken", TIMEOUT_SHORT);

		compare_value("motor state", mk == 16'hEAEA, o_motor_state);
		compare_value("motor direction", dk == 16'h1EAF, o_motor_direction);
		compare_value("alarm reset", ak == 16'hAAED, o_motor_alarm_reset);

		// Frames and status report
		wait_until(SIG_BURST, "status burst", TIMEOUT_SEQ);
		compare_value("frame count", frames_before + 3, u_dac_model.frame_count);
		compare_value("write frame", {4'h3, 4'h9, volt, 6'd0},
			u_dac_model.frame_log[frames_before]);
		compare_value("read frame", {4'h9, 4'h1, 16'd0},
			u_dac_model.frame_log[frames_before + 1]);
		compare_value("no-op frame", 24'd0, u_dac_model.frame_log[frames_before + 2]);
		compare_value("status address", 32'h1000, aw_addr);
		compare_value("status length", 8'd1, aw_len);
		compare_value("status burst type", 2'b01, aw_burst);
		compare_value("status id", bursts_target % 16, aw_id);
		compare_value("status beat one", {(mk == 16'hEAEA) ? 16'hEAEA : 16'h0000,
			(dk == 16'h1EAF) ? 16'h1EAF : 16'h0000, 6'd0, volt,
			corrupt ? 16'h0000 : 16'hFBFB}, beat_data[0]);
		compare_value("status beat two", {period, 32'd0}, beat_data[1]);
		compare_value("status last flags", 2'b10, {beat_last[1], beat_last[0]});
		compare_value("status strobes", 16'hFFFF, {beat_strb[1], beat_strb[0]});

		// Trigger spacing or silence
		if (mk == 16'hEAEA) begin
			wait_until(SIG_TRIG, "first trigger pulse", int'(period) + TIMEOUT_SHORT);
			@(negedge sys_clk);
			gap = 1;
			while (!o_trig_ad_convst && gap <= int'(period) + 1) begin
				@(negedge sys_clk);
				gap++;
			end
			compare_value("trigger gap", period + 32'd1, gap);
		end else begin
			for (n = 0; n < IDLE_WINDOW; n++) begin
				compare_value("trigger idle", 1'b0, o_trig_ad_convst);
				@(negedge sys_clk);
			end
		end
	endtask

	initial begin
		int          fd;
		int          cmd_count;
		string       line;
		logic [31:0] f_motor, f_dir, f_volt, f_alarm, f_period, f_corrupt;
		cmd_count   = 0;
		sys_rst     = 1'b1;
		i_s_awvalid = 1'b0;
		i_s_wvalid  = 1'b0;
		i_s_wdata   = '0;
		i_s_wlast   = 1'b0;
		i_s_bready  = 1'b0;
		i_m_awready = 1'b0;
		i_m_wready  = 1'b0;
		i_m_bvalid  = 1'b0;
		cur_volt    = '0;
		cur_corrupt = 1'b0;
		repeat (10) @(posedge sys_clk);
		@(negedge sys_clk);
		// Nine lows, then sync_n high, reset_n low, direction high
		compare_value("reset outputs", 12'b0000_0000_0101,
			{o_s_awready, o_s_wready, o_s_bvalid, o_m_awvalid, o_m_wvalid, o_m_bready,
			o_motor_state, o_motor_alarm_reset, o_trig_ad_convst,
			o_dac_sync_n, o_dac_reset_n, o_motor_direction});
		sys_rst = 1'b0;
		wait_until(SIG_RESET_N, "DAC reset release", TIMEOUT_SHORT);

		fd = $fopen("bench/motor_dac_vectors.txt", "r");
		if (fd == 0) begin
			fail_run("could not open bench/motor_dac_vectors.txt");
		end else begin
			while ($fgets(line, fd)) begin
				if ($sscanf(line, "%h %h %h %h %h %h", f_motor, f_dir, f_volt, f_alarm,
					f_period, f_corrupt) != 6)
					continue;	// Comment or blank line
				run_vector(f_motor[15:0], f_dir[15:0], f_volt[9:0], f_alarm[15:0],
					f_period, f_corrupt[0]);
				cmd_count++;
			end
			$fclose(fd);
		end
		if (cmd_count == 0) begin
			fail_run("the vector file held no commands");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sim.f */
verilog/motor_dac_pkg.sv
verilog/axi_cmd_slave.sv
verilog/motor_cmd_regs.sv
verilog/dac_frame_shifter.sv
verilog/dac_sequencer.sv
verilog/convst_timer.sv
verilog/status_writer.sv
verilog/motor_dac_ctrl.sv
bench/tb_dac_model.sv
bench/tb_motor_dac_ctrl.sv

/* verilog/axi_cmd_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_cmd_slave import motor_dac_pkg::*; (
	input  wire                  sys_clk,
	input  wire                  sys_rst,
	input  wire                  i_s_awvalid,
	input  wire                  i_s_wvalid,
	input  wire [AXI_DATA_W-1:0] i_s_wdata,
	input  wire                  i_s_wlast,
	input  wire                  i_s_bready,
	output logic                 o_s_awready,
	output logic                 o_s_wready,
	output logic                 o_s_bvalid,
	output logic [1:0]           o_s_bresp,
	output logic                 o_beat_valid,
	output logic                 o_beat_first,
	output cmd_word_t            o_beat_data
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ADDR = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;
	localparam logic [1:0] ST_RESP = 2'd3;

	logic [1:0] state;
	logic       first_pend;	// Next beat is beat one
	logic       w_fire;

	assign w_fire    = i_s_wvalid & o_s_wready;
	assign o_s_bresp = RESP_OKAY;	// Never an error

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state        <= ST_IDLE;
			o_s_awready  <= 1'b0;
			o_s_wready   <= 1'b0;
			o_s_bvalid   <= 1'b0;
			o_beat_valid <= 1'b0;
			first_pend   <= 1'b0;
		end else begin
			o_beat_valid <= w_fire;	// Beat strobe one cycle late
			case (state)
				ST_IDLE: if (i_s_awvalid) begin
					o_s_awready <= 1'b1;	// One-cycle pulse
					state       <= ST_ADDR;
				end
				ST_ADDR: begin	// Address taken here, value ignored
					o_s_awready <= 1'b0;
					o_s_wready  <= 1'b1;
					first_pend  <= 1'b1;
					state       <= ST_DATA;
				end
				ST_DATA: if (w_fire) begin
					first_pend <= 1'b0;
					if (i_s_wlast) begin
						o_s_wready <= 1'b0;
						o_s_bvalid <= 1'b1;
						state      <= ST_RESP;
					end
				end
				default: if (i_s_bready) begin	// Hold response until taken
					o_s_bvalid <= 1'b0;
					state      <= ST_IDLE;
				end
			endcase
		end
	end

	// Beat payload
	always_ff @(posedge sys_clk) begin
		if (w_fire) begin
			o_beat_data  <= i_s_wdata;
			o_beat_first <= first_pend;
		end
	end

endmodule

`default_nettype wire

/* verilog/convst_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module convst_timer (
	input  wire        sys_clk,
	input  wire        sys_rst,
	input  wire        i_run,
	input  wire [31:0] i_period,
	output logic       o_trig_ad_convst
);

	logic [31:0] cnt;

	// One pulse every period plus one cycles
	always_ff @(posedge sys_clk) begin
		if (sys_rst || !i_run) begin	// Idle while motor off
			cnt              <= '0;
			o_trig_ad_convst <= 1'b0;
		end else if (cnt == i_period) begin
			cnt              <= '0;
			o_trig_ad_convst <= 1'b1;
		end else begin
			cnt              <= cnt + 1'b1;
			o_trig_ad_convst <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/dac_frame_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_frame_shifter import motor_dac_pkg::*; #(
	parameter int SCLK_DIV = 6	// sys_clk cycles per serial clock, even
) (
	input  wire                    sys_clk,
	input  wire                    sys_rst,
	input  wire                    i_frame_start,
	input  wire  [DAC_FRAME_W-1:0] i_frame_tx,
	input  wire                    i_dac_sdo,
	output logic                   o_frame_done,
	output logic [DAC_FRAME_W-1:0] o_frame_rx,
	output logic                   o_sclk_fall,
	output logic                   o_dac_sclk,
	output logic                   o_dac_sync_n,
	output logic                   o_dac_sdin
);

	localparam int DIV_W = $clog2(SCLK_DIV);
	localparam int CNT_W = $clog2(DAC_FRAME_W);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_GAP   = 2'd1;
	localparam logic [1:0] ST_SHIFT = 2'd2;

	logic [DIV_W-1:0]       div_cnt;
	logic                   sclk_rise;
	logic [1:0]             state;
	logic [CNT_W-1:0]       bit_cnt;
	logic [DAC_FRAME_W-1:0] tx_sr;

	// ****************************************
	// Free-running serial clock
	// ****************************************
	assign sclk_rise   = (div_cnt == DIV_W'(SCLK_DIV - 1));
	assign o_sclk_fall = (div_cnt == DIV_W'(SCLK_DIV / 2 - 1));

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			div_cnt    <= '0;
			o_dac_sclk <= 1'b0;
		end else begin
			div_cnt <= sclk_rise ? '0 : div_cnt + 1'b1;
			if (sclk_rise)
				o_dac_sclk <= 1'b1;
			else if (o_sclk_fall)
				o_dac_sclk <= 1'b0;
		end
	end

	// ****************************************
	// Frame: sync gap then 24 bits MSB first
	// ****************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state        <= ST_IDLE;
			bit_cnt      <= '0;
			o_dac_sync_n <= 1'b1;
			o_dac_sdin   <= 1'b0;
			o_frame_done <= 1'b0;
		end else begin
			o_frame_done <= 1'b0;
			case (state)
				ST_IDLE: if (i_frame_start) begin
					bit_cnt <= '0;
					state   <= ST_GAP;
				end
				ST_GAP: if (o_sclk_fall) begin
					if (bit_cnt == CNT_W'(DAC_SYNC_GAP - 1)) begin
						o_dac_sync_n <= 1'b0;
						o_dac_sdin   <= tx_sr[DAC_FRAME_W-1];	// First bit
						bit_cnt      <= '0;
						state        <= ST_SHIFT;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: if (o_sclk_fall) begin	// SDIN moves on falling edges
					if (bit_cnt == CNT_W'(DAC_FRAME_W - 1)) begin
						o_dac_sync_n <= 1'b1;
						o_dac_sdin   <= 1'b0;
						o_frame_done <= 1'b1;
						state        <= ST_IDLE;
					end else begin
						o_dac_sdin <= tx_sr[DAC_FRAME_W-2];
						bit_cnt    <= bit_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// Payload shift registers
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE && i_frame_start)
			tx_sr <= i_frame_tx;
		else if (state == ST_SHIFT && o_sclk_fall)
			tx_sr <= {tx_sr[DAC_FRAME_W-2:0], 1'b0};
		if (state == ST_SHIFT && sclk_rise)
			o_frame_rx <= {o_frame_rx[DAC_FRAME_W-2:0], i_dac_sdo};	// SDO on rising edge
	end

endmodule

`default_nettype wire

/* verilog/dac_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_sequencer import motor_dac_pkg::*; (
	input  wire                    sys_clk,
	input  wire                    sys_rst,
	input  wire                    i_dac_start,
	input  wire  [DAC_VOLT_W-1:0]  i_dac_voltage,
	input  wire                    i_frame_done,
	input  wire  [DAC_FRAME_W-1:0] i_frame_rx,
	input  wire                    i_sclk_fall,
	output logic                   o_dac_reset_n,
	output logic                   o_frame_start,
	output logic [DAC_FRAME_W-1:0] o_frame_tx,
	output logic                   o_seq_done,
	output logic                   o_dac_ok
);

	localparam int RST_W = $clog2(DAC_RESET_SCLKS + 1);

	localparam logic [1:0] ST_RESET = 2'd0;
	localparam logic [1:0] ST_IDLE  = 2'd1;
	localparam logic [1:0] ST_WAIT  = 2'd2;
	localparam logic [1:0] ST_CHECK = 2'd3;

	logic [1:0]             state;
	logic [RST_W-1:0]       rst_cnt;
	logic [1:0]             frame_idx;	// 0 write, 1 read, 2 no-op
	logic [DAC_FRAME_W-1:0] write_frame;
	logic [DAC_FRAME_W-1:0] read_frame;

	assign write_frame = {DAC_CMD_WRITE, DAC_ADDR_ALL, i_dac_voltage, 6'd0};
	assign read_frame  = {DAC_CMD_READ, DAC_ADDR_A, 16'd0};

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state         <= ST_RESET;
			rst_cnt       <= '0;
			frame_idx     <= '0;
			o_dac_reset_n <= 1'b0;
			o_frame_start <= 1'b0;
			o_seq_done    <= 1'b0;
			o_dac_ok      <= 1'b0;
		end else begin
			o_frame_start <= 1'b0;
			o_seq_done    <= 1'b0;
			case (state)
				// ****************************************
				// Power-up reset, counted in serial clocks
				// ****************************************
				ST_RESET: if (i_sclk_fall) begin
					rst_cnt <= rst_cnt + 1'b1;
					if (rst_cnt == RST_W'(DAC_RESET_SCLKS - 1)) begin
						o_dac_reset_n <= 1'b1;
						state         <= ST_IDLE;
					end
				end
				ST_IDLE: if (i_dac_start) begin	// Starts ignored elsewhere
					frame_idx     <= '0;
					o_frame_tx    <= write_frame;
					o_frame_start <= 1'b1;
					state         <= ST_WAIT;
				end
				ST_WAIT: if (i_frame_done) begin
					if (frame_idx == 2'd2) begin
						state <= ST_CHECK;	// Readback in from no-op
					end else begin
						frame_idx     <= frame_idx + 1'b1;
						o_frame_tx    <= (frame_idx == 2'd0) ? read_frame : '0;
						o_frame_start <= 1'b1;
					end
				end
				default: begin
					o_dac_ok   <= (i_frame_rx[11:2] == i_dac_voltage);
					o_seq_done <= 1'b1;
					state      <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/motor_cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_cmd_regs import motor_dac_pkg::*; (
	input  wire                   sys_clk,
	input  wire                   sys_rst,
	input  wire                   i_beat_valid,
	input  wire                   i_beat_first,
	input  cmd_word_t             i_beat_data,
	output logic                  o_motor_state,
	output logic                  o_motor_direction,
	output logic                  o_motor_alarm_reset,
	output logic [DAC_VOLT_W-1:0] o_dac_voltage,
	output logic [31:0]           o_trig_period,
	output logic                  o_dac_start
);

	logic period_loaded;	// Second beat just latched

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			o_motor_state       <= 1'b0;
			o_motor_direction   <= 1'b1;	// Positive at power-up
			o_motor_alarm_reset <= 1'b0;
			o_dac_voltage       <= '0;
			o_trig_period       <= '0;
			period_loaded       <= 1'b0;
			o_dac_start         <= 1'b0;
		end else begin
			period_loaded <= i_beat_valid & ~i_beat_first;
			o_dac_start   <= period_loaded;	// Start after period update

			// ****************************************
			// Beat one is the field view
			// ****************************************
			if (i_beat_valid && i_beat_first) begin
				o_motor_state       <= (i_beat_data.f.motor_key == KEY_MOTOR_EN);
				o_motor_direction   <= (i_beat_data.f.dir_key == KEY_DIR_POS);
				o_motor_alarm_reset <= (i_beat_data.f.tag_key == KEY_ALARM_RST);
				o_dac_voltage       <= i_beat_data.f.volt_half[DAC_VOLT_W-1:0];
			end

			// Beat two is the period view
			if (i_beat_valid && !i_beat_first)
				o_trig_period <= i_beat_data.p.period;
		end
	end

endmodule

`default_nettype wire

/* verilog/motor_dac_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_dac_ctrl import motor_dac_pkg::*; #(
	parameter int                    SCLK_DIV    = 6,
	parameter logic [AXI_ADDR_W-1:0] STATUS_ADDR = '0
) (
	input  wire                    sys_clk,
	input  wire                    sys_rst,
	// Command slave
	input  wire                    i_s_awvalid,
	output logic                   o_s_awready,
	input  wire                    i_s_wvalid,
	output logic                   o_s_wready,
	input  wire  [AXI_DATA_W-1:0]  i_s_wdata,
	input  wire                    i_s_wlast,
	output logic                   o_s_bvalid,
	output logic [1:0]             o_s_bresp,
	input  wire                    i_s_bready,
	// Status master
	output logic                   o_m_awvalid,
	input  wire                    i_m_awready,
	output logic [AXI_ADDR_W-1:0]  o_m_awaddr,
	output logic [AXI_ID_W-1:0]    o_m_awid,
	output logic [AXI_LEN_W-1:0]   o_m_awlen,
	output logic [1:0]             o_m_awburst,
	output logic                   o_m_wvalid,
	input  wire                    i_m_wready,
	output logic [AXI_DATA_W-1:0]  o_m_wdata,
	output logic [AXI_DATA_W/8-1:0] o_m_wstrb,
	output logic                   o_m_wlast,
	input  wire                    i_m_bvalid,
	output logic                   o_m_bready,
	// DAC pins
	output logic                   o_dac_sclk,
	output logic                   o_dac_sync_n,
	output logic                   o_dac_sdin,
	output logic                   o_dac_reset_n,
	input  wire                    i_dac_sdo,
	// Motor pins
	output logic                   o_motor_state,
	output logic                   o_motor_direction,
	output logic                   o_motor_alarm_reset,
	output logic                   o_trig_ad_convst
);

	// ****************************************
	// Internal strobes and settings
	// ****************************************
	logic                   beat_valid;
	logic                   beat_first;
	cmd_word_t              beat_data;
	logic [DAC_VOLT_W-1:0]  dac_voltage;
	logic [31:0]            trig_period;
	logic                   dac_start;
	logic                   frame_start;
	logic                   frame_done;
	logic [DAC_FRAME_W-1:0] frame_tx;
	logic [DAC_FRAME_W-1:0] frame_rx;
	logic                   sclk_fall;
	logic                   seq_done;
	logic                   dac_ok;

	axi_cmd_slave u_axi_cmd_slave (
		.sys_clk, .sys_rst,
		.i_s_awvalid, .i_s_wvalid, .i_s_wdata, .i_s_wlast, .i_s_bready,
		.o_s_awready, .o_s_wready, .o_s_bvalid, .o_s_bresp,
		.o_beat_valid (beat_valid),
		.o_beat_first (beat_first),
		.o_beat_data  (beat_data)
	);

	motor_cmd_regs u_motor_cmd_regs (
		.sys_clk, .sys_rst,
		.i_beat_valid (beat_valid),
		.i_beat_first (beat_first),
		.i_beat_data  (beat_data),
		.o_motor_state, .o_motor_direction, .o_motor_alarm_reset,
		.o_dac_voltage (dac_voltage),
		.o_trig_period (trig_period),
		.o_dac_start   (dac_start)
	);

	dac_frame_shifter #(.SCLK_DIV(SCLK_DIV)) u_dac_frame_shifter (
		.sys_clk, .sys_rst,
		.i_frame_start (frame_start),
		.i_frame_tx    (frame_tx),
		.i_dac_sdo,
		.o_frame_done  (frame_done),
		.o_frame_rx    (frame_rx),
		.o_sclk_fall   (sclk_fall),
		.o_dac_sclk, .o_dac_sync_n, .o_dac_sdin
	);

	dac_sequencer u_dac_sequencer (
		.sys_clk, .sys_rst,
		.i_dac_start   (dac_start),
		.i_dac_voltage (dac_voltage),
		.i_frame_done  (frame_done),
		.i_frame_rx    (frame_rx),
		.i_sclk_fall   (sclk_fall),
		.o_dac_reset_n,
		.o_frame_start (frame_start),
		.o_frame_tx    (frame_tx),
		.o_seq_done    (seq_done),
		.o_dac_ok      (dac_ok)
	);

	convst_timer u_convst_timer (
		.sys_clk, .sys_rst,
		.i_run    (o_motor_state),	// Trigger only while motor runs
		.i_period (trig_period),
		.o_trig_ad_convst
	);

	status_writer #(.STATUS_ADDR(STATUS_ADDR)) u_status_writer (
		.sys_clk, .sys_rst,
		.i_seq_done        (seq_done),
		.i_dac_ok          (dac_ok),
		.i_motor_state     (o_motor_state),
		.i_motor_direction (o_motor_direction),
		.i_dac_voltage     (dac_voltage),
		.i_trig_period     (trig_period),
		.i_m_awready, .i_m_wready, .i_m_bvalid,
		.o_m_awvalid, .o_m_awaddr, .o_m_awid, .o_m_awlen, .o_m_awburst,
		.o_m_wvalid, .o_m_wdata, .o_m_wstrb, .o_m_wlast, .o_m_bready
	);

endmodule

`default_nettype wire

/* verilog/motor_dac_pkg.sv */
`default_nettype none

package motor_dac_pkg;

	// ****************************************
	// AXI widths and codes
	// ****************************************
	localparam int AXI_DATA_W = 64;
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_ID_W   = 4;
	localparam int AXI_LEN_W  = 8;

	localparam logic [1:0] BURST_INCR = 2'b01;
	localparam logic [1:0] RESP_OKAY  = 2'b00;

	// Command and status keys
	localparam logic [15:0] KEY_MOTOR_EN  = 16'hEAEA;
	localparam logic [15:0] KEY_DIR_POS   = 16'h1EAF;
	localparam logic [15:0] KEY_ALARM_RST = 16'hAAED;
	localparam logic [15:0] KEY_DAC_OK    = 16'hFBFB;	// Readback matched

	// ****************************************
	// Serial DAC
	// ****************************************
	localparam int DAC_VOLT_W  = 10;
	localparam int DAC_FRAME_W = 24;

	localparam logic [3:0] DAC_CMD_WRITE = 4'd3;
	localparam logic [3:0] DAC_CMD_READ  = 4'd9;
	localparam logic [3:0] DAC_ADDR_ALL  = 4'd9;
	localparam logic [3:0] DAC_ADDR_A    = 4'd1;

	localparam int DAC_RESET_SCLKS = 4;	// Reset low after power-up
	localparam int DAC_SYNC_GAP    = 10;	// Sync high before a frame

	// One 64-bit word, fields on beat one, period on beat two
	typedef union packed {
		struct packed {
			logic [15:0] motor_key;
			logic [15:0] dir_key;
			logic [15:0] volt_half;	// Voltage in low bits
			logic [15:0] tag_key;	// Alarm reset or DAC ok
		} f;
		struct packed {
			logic [31:0] period;
			logic [31:0] unused;
		} p;
	} cmd_word_t;

endpackage

`default_nettype wire

/* verilog/status_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module status_writer import motor_dac_pkg::*; #(
	parameter logic [AXI_ADDR_W-1:0] STATUS_ADDR = '0
) (
	input  wire                     sys_clk,
	input  wire                     sys_rst,
	input  wire                     i_seq_done,
	input  wire                     i_dac_ok,
	input  wire                     i_motor_state,
	input  wire                     i_motor_direction,
	input  wire  [DAC_VOLT_W-1:0]   i_dac_voltage,
	input  wire  [31:0]             i_trig_period,
	input  wire                     i_m_awready,
	input  wire                     i_m_wready,
	input  wire                     i_m_bvalid,
	output logic                    o_m_awvalid,
	output logic [AXI_ADDR_W-1:0]   o_m_awaddr,
	output logic [AXI_ID_W-1:0]     o_m_awid,
	output logic [AXI_LEN_W-1:0]    o_m_awlen,
	output logic [1:0]              o_m_awburst,
	output logic                    o_m_wvalid,
	output logic [AXI_DATA_W-1:0]   o_m_wdata,
	output logic [AXI_DATA_W/8-1:0] o_m_wstrb,
	output logic                    o_m_wlast,
	output logic                    o_m_bready
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ADDR = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;
	localparam logic [1:0] ST_RESP = 2'd3;

	logic [1:0] state;
	logic       pending;	// One report waiting behind a busy burst
	cmd_word_t  beat_a;
	cmd_word_t  beat_b;
	cmd_word_t  hold_b;	// Second beat frozen at launch

	// Fixed burst shape, two beats
	assign o_m_awaddr  = STATUS_ADDR;
	assign o_m_awlen   = AXI_LEN_W'(1);
	assign o_m_awburst = BURST_INCR;
	assign o_m_wstrb   = '1;

	always_comb begin
		beat_a.f.motor_key = i_motor_state ? KEY_MOTOR_EN : 16'd0;
		beat_a.f.dir_key   = i_motor_direction ? KEY_DIR_POS : 16'd0;
		beat_a.f.volt_half = {{(16 - DAC_VOLT_W){1'b0}}, i_dac_voltage};
		beat_a.f.tag_key   = i_dac_ok ? KEY_DAC_OK : 16'd0;
		beat_b.p.period    = i_trig_period;
		beat_b.p.unused    = '0;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state       <= ST_IDLE;
			pending     <= 1'b0;
			o_m_awid    <= '0;	// First burst gets id 1
			o_m_awvalid <= 1'b0;
			o_m_wvalid  <= 1'b0;
			o_m_wlast   <= 1'b0;
			o_m_bready  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (i_seq_done || pending) begin
					pending     <= 1'b0;
					o_m_awid    <= o_m_awid + 1'b1;
					o_m_awvalid <= 1'b1;
					o_m_wdata   <= beat_a;
					hold_b      <= beat_b;
					state       <= ST_ADDR;
				end
				ST_ADDR: if (i_m_awready) begin
					o_m_awvalid <= 1'b0;
					o_m_wvalid  <= 1'b1;
					state       <= ST_DATA;
				end
				ST_DATA: if (i_m_wready) begin
					if (o_m_wlast) begin
						o_m_wvalid <= 1'b0;
						o_m_wlast  <= 1'b0;
						o_m_bready <= 1'b1;
						state      <= ST_RESP;
					end else begin
						o_m_wdata <= hold_b;	// Period beat, last
						o_m_wlast <= 1'b1;
					end
				end
				default: if (i_m_bvalid) begin
					o_m_bready <= 1'b0;
					state      <= ST_IDLE;
				end
			endcase
			if (i_seq_done && state != ST_IDLE)
				pending <= 1'b1;
		end
	end

endmodule

`default_nettype wire
